// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // base opcodes of the kept instructions
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  // add is zero so an empty payload still decodes cleanly
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_imm, wb_pc4} wb_sel_e;

  typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb} fwd_sel_e;

  typedef enum logic [1:0] {cut_flush, cut_hold, cut_push} cut_sel_e;

  typedef struct packed {
    logic       rf_write;
    logic       alu_src_imm;
    logic       dm_en;
    logic       dm_write;
    logic       branch;
    logic       jump;
    wb_sel_e    wb_sel;
    alu_op_e    alu_op;
    logic [2:0] funct3;
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     pc;
    word_t     rs1_val;
    word_t     rs2_val;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
  } id_ex_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     pc;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t rd;
    word_t     imm;
  } ex_mem_t;

  typedef struct packed {
    logic      rf_write;
    wb_sel_e   wb_sel;
    reg_addr_t rd;
    word_t     alu_result;
    word_t     load_data;
    word_t     imm;
    word_t     pc;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== core/stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic             clk,
  input  rv_pkg::cut_sel_e sel,
  input  payload_t         d,
  output payload_t         q
);

  // an all-zero payload has no register or memory write
  always_ff @(posedge clk) begin
    case (sel)
      rv_pkg::cut_flush: q <= '0;
      rv_pkg::cut_push:  q <= d;
      default:           q <= q;
    endcase
  end

endmodule

`default_nettype wire

// ==== core/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  rv_pkg::word_t     instr,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::reg_addr_t rd_addr,
  output rv_pkg::word_t     imm,
  output rv_pkg::ctrl_t     ctrl
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            alt;
  logic            use_rs1;
  logic            use_rs2;
  rv_pkg::alu_op_e alu_op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign alt    = instr[30];

  // bit 30 selects sub only for register ops, sra for both forms
  always_comb begin
    case (funct3)
      3'b000:  alu_op = (alt && opcode == rv_pkg::op_reg) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  alu_op = rv_pkg::alu_sll;
      3'b010:  alu_op = rv_pkg::alu_slt;
      3'b011:  alu_op = rv_pkg::alu_sltu;
      3'b100:  alu_op = rv_pkg::alu_xor;
      3'b101:  alu_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  alu_op = rv_pkg::alu_or;
      default: alu_op = rv_pkg::alu_and;
    endcase
  end

  // main control and immediate select
  always_comb begin
    ctrl    = '0;
    imm     = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      rv_pkg::op_reg: begin
        ctrl.rf_write = 1'b1;
        ctrl.alu_op   = alu_op;
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
      end
      rv_pkg::op_imm: begin
        ctrl.rf_write    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_op;
        imm              = {{20{instr[31]}}, instr[31:20]};
        use_rs1          = 1'b1;
      end
      rv_pkg::op_lui: begin
        ctrl.rf_write = 1'b1;
        ctrl.wb_sel   = rv_pkg::wb_imm;
        imm           = {instr[31:12], 12'b0};
      end
      rv_pkg::op_load: begin
        ctrl.rf_write    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.dm_en       = 1'b1;
        ctrl.wb_sel      = rv_pkg::wb_mem;
        imm              = {{20{instr[31]}}, instr[31:20]};
        use_rs1          = 1'b1;
      end
      rv_pkg::op_store: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.dm_en       = 1'b1;
        ctrl.dm_write    = 1'b1;
        imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        use_rs1          = 1'b1;
        use_rs2          = 1'b1;
      end
      rv_pkg::op_branch: begin
        ctrl.branch = 1'b1;
        ctrl.funct3 = funct3;
        imm         = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
      end
      rv_pkg::op_jal: begin
        ctrl.rf_write = 1'b1;
        ctrl.jump     = 1'b1;
        ctrl.wb_sel   = rv_pkg::wb_pc4;
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: ;
    endcase
  end

  // unused fields read as x0, so they never trigger forwarding or bubbles
  assign rs1_addr = use_rs1 ? instr[19:15] : '0;
  assign rs2_addr = use_rs2 ? instr[24:20] : '0;
  assign rd_addr  = ctrl.rf_write ? instr[11:7] : '0;

endmodule

`default_nettype wire

// ==== core/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              wr_en,
  input  rv_pkg::reg_addr_t wr_addr,
  input  rv_pkg::word_t     wr_data
);

  // x0 has no storage
  rv_pkg::word_t regs [31:1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== core/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_pkg::alu_add:  result = a + b;
      rv_pkg::alu_sub:  result = a - b;
      rv_pkg::alu_sll:  result = a << shamt;
      rv_pkg::alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::alu_sltu: result = {31'b0, a < b};
      rv_pkg::alu_xor:  result = a ^ b;
      rv_pkg::alu_srl:  result = a >> shamt;
      // arithmetic shift keeps the sign bit
      rv_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);
      rv_pkg::alu_or:   result = a | b;
      rv_pkg::alu_and:  result = a & b;
      default:          result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== core/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  rv_pkg::reg_addr_t id_rs1,
  input  rv_pkg::reg_addr_t id_rs2,
  input  rv_pkg::reg_addr_t ex_rs1,
  input  rv_pkg::reg_addr_t ex_rs2,
  input  rv_pkg::reg_addr_t ex_rd,
  input  rv_pkg::reg_addr_t mem_rd,
  input  rv_pkg::reg_addr_t wb_rd,
  input  logic              id_branch,
  input  logic              ex_rf_write,
  input  logic              ex_is_load,
  input  logic              mem_rf_write,
  input  logic              mem_is_load,
  input  logic              wb_rf_write,
  input  logic              rst,
  input  logic              stall,
  input  logic              redirect,
  output rv_pkg::fwd_sel_e  fwd_ex_a,
  output rv_pkg::fwd_sel_e  fwd_ex_b,
  output rv_pkg::fwd_sel_e  fwd_id_a,
  output rv_pkg::fwd_sel_e  fwd_id_b,
  output rv_pkg::cut_sel_e  cut_if_id,
  output rv_pkg::cut_sel_e  cut_id_ex,
  output rv_pkg::cut_sel_e  cut_ex_mem,
  output rv_pkg::cut_sel_e  cut_mem_wb,
  output logic              pc_hold
);

  logic load_use;
  logic branch_wait;
  logic bubble;

  // writer with a nonzero rd that matches the source
  function automatic logic hit(input logic wr, input rv_pkg::reg_addr_t rd,
                               input rv_pkg::reg_addr_t src);
    return wr && rd != '0 && rd == src;
  endfunction

  // memory stage wins over writeback, it is the younger result
  function automatic rv_pkg::fwd_sel_e pick(input logic mem_hit, input logic wb_hit);
    if (mem_hit) begin
      return rv_pkg::fwd_mem;
    end
    return wb_hit ? rv_pkg::fwd_wb : rv_pkg::fwd_reg;
  endfunction

  assign fwd_ex_a = pick(hit(mem_rf_write, mem_rd, ex_rs1), hit(wb_rf_write, wb_rd, ex_rs1));
  assign fwd_ex_b = pick(hit(mem_rf_write, mem_rd, ex_rs2), hit(wb_rf_write, wb_rd, ex_rs2));
  assign fwd_id_a = pick(hit(mem_rf_write, mem_rd, id_rs1), hit(wb_rf_write, wb_rd, id_rs1));
  assign fwd_id_b = pick(hit(mem_rf_write, mem_rd, id_rs2), hit(wb_rf_write, wb_rd, id_rs2));

  assign load_use = hit(ex_is_load, ex_rd, id_rs1) || hit(ex_is_load, ex_rd, id_rs2);

  // branch compares in decode, so its sources must be forwardable already
  assign branch_wait = id_branch &&
                       (hit(ex_rf_write, ex_rd, id_rs1) || hit(ex_rf_write, ex_rd, id_rs2) ||
                        hit(mem_is_load, mem_rd, id_rs1) || hit(mem_is_load, mem_rd, id_rs2));

  assign bubble = load_use || branch_wait;

  // ==========================================================================
  // stage register priority
  // ==========================================================================

  always_comb begin
    cut_if_id  = rv_pkg::cut_push;
    cut_id_ex  = rv_pkg::cut_push;
    cut_ex_mem = rv_pkg::cut_push;
    cut_mem_wb = rv_pkg::cut_push;
    pc_hold    = 1'b0;
    if (rst) begin
      cut_if_id  = rv_pkg::cut_flush;
      cut_id_ex  = rv_pkg::cut_flush;
      cut_ex_mem = rv_pkg::cut_flush;
      cut_mem_wb = rv_pkg::cut_flush;
    end else if (stall) begin
      cut_if_id  = rv_pkg::cut_hold;
      cut_id_ex  = rv_pkg::cut_hold;
      cut_ex_mem = rv_pkg::cut_hold;
      cut_mem_wb = rv_pkg::cut_hold;
      pc_hold    = 1'b1;
    end else if (redirect && !bubble) begin
      // a waiting branch compared stale operands, its redirect is not real yet
      cut_if_id = rv_pkg::cut_flush;
    end else if (bubble) begin
      cut_if_id = rv_pkg::cut_hold;
      cut_id_ex = rv_pkg::cut_flush;
      pc_hold   = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== core/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic          clk,
  input  logic          rst,
  input  logic          stall,
  output rv_pkg::word_t im_addr,
  input  rv_pkg::word_t im_rdata,
  output logic          dm_en,
  output logic          dm_write,
  output rv_pkg::word_t dm_addr,
  output rv_pkg::word_t dm_wdata,
  input  rv_pkg::word_t dm_rdata
);

  rv_pkg::if_id_t    if_d, if_q;
  rv_pkg::id_ex_t    id_d, id_q;
  rv_pkg::ex_mem_t   ex_d, ex_q;
  rv_pkg::mem_wb_t   mem_d, mem_q;

  rv_pkg::cut_sel_e  cut_if_id, cut_id_ex, cut_ex_mem, cut_mem_wb;
  rv_pkg::fwd_sel_e  fwd_ex_a, fwd_ex_b, fwd_id_a, fwd_id_b;
  logic              pc_hold;
  logic              redirect;
  logic              taken;

  rv_pkg::word_t     pc;
  rv_pkg::word_t     target;
  rv_pkg::reg_addr_t id_rs1, id_rs2, id_rd;
  rv_pkg::word_t     id_imm;
  rv_pkg::ctrl_t     id_ctrl;
  rv_pkg::word_t     rf_a, rf_b;
  rv_pkg::word_t     id_a, id_b;
  rv_pkg::word_t     ex_a, ex_b, alu_b, alu_result;
  rv_pkg::word_t     mem_fwd;
  rv_pkg::word_t     wb_data;

  function automatic rv_pkg::word_t fwd_mux(input rv_pkg::fwd_sel_e sel,
                                            input rv_pkg::word_t reg_val,
                                            input rv_pkg::word_t mem_val,
                                            input rv_pkg::word_t wb_val);
    case (sel)
      rv_pkg::fwd_mem: return mem_val;
      rv_pkg::fwd_wb:  return wb_val;
      default:         return reg_val;
    endcase
  endfunction

  // ==========================================================================
  // fetch
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!pc_hold) begin
      pc <= redirect ? target : pc + 32'd4;
    end
  end

  assign im_addr    = pc;
  assign if_d.pc    = pc;
  assign if_d.instr = im_rdata;

  stage_reg #(.payload_t(rv_pkg::if_id_t)) if_id_reg (
    .clk(clk), .sel(cut_if_id), .d(if_d), .q(if_q)
  );

  // ==========================================================================
  // decode, branch resolve
  // ==========================================================================

  decode_unit decode_unit_inst (
    .instr(if_q.instr),
    .rs1_addr(id_rs1),
    .rs2_addr(id_rs2),
    .rd_addr(id_rd),
    .imm(id_imm),
    .ctrl(id_ctrl)
  );

  reg_file reg_file_inst (
    .clk(clk),
    .rst(rst),
    .rs1_addr(id_rs1),
    .rs2_addr(id_rs2),
    .rs1_data(rf_a),
    .rs2_data(rf_b),
    .wr_en(mem_q.rf_write),
    .wr_addr(mem_q.rd),
    .wr_data(wb_data)
  );

  assign id_a = fwd_mux(fwd_id_a, rf_a, mem_fwd, wb_data);
  assign id_b = fwd_mux(fwd_id_b, rf_b, mem_fwd, wb_data);

  always_comb begin
    case (id_ctrl.funct3)
      3'b000:  taken = id_a == id_b;
      3'b001:  taken = id_a != id_b;
      3'b100:  taken = $signed(id_a) < $signed(id_b);
      3'b101:  taken = $signed(id_a) >= $signed(id_b);
      3'b110:  taken = id_a < id_b;
      3'b111:  taken = id_a >= id_b;
      default: taken = 1'b0;
    endcase
  end

  // both branch and jal targets are pc relative
  assign redirect = id_ctrl.jump || (id_ctrl.branch && taken);
  assign target   = if_q.pc + id_imm;

  assign id_d.ctrl    = id_ctrl;
  assign id_d.pc      = if_q.pc;
  assign id_d.rs1_val = id_a;
  assign id_d.rs2_val = id_b;
  assign id_d.rs1     = id_rs1;
  assign id_d.rs2     = id_rs2;
  assign id_d.rd      = id_rd;
  assign id_d.imm     = id_imm;

  stage_reg #(.payload_t(rv_pkg::id_ex_t)) id_ex_reg (
    .clk(clk), .sel(cut_id_ex), .d(id_d), .q(id_q)
  );

  // ==========================================================================
  // execute
  // ==========================================================================

  assign ex_a  = fwd_mux(fwd_ex_a, id_q.rs1_val, mem_fwd, wb_data);
  assign ex_b  = fwd_mux(fwd_ex_b, id_q.rs2_val, mem_fwd, wb_data);
  assign alu_b = id_q.ctrl.alu_src_imm ? id_q.imm : ex_b;

  alu alu_inst (
    .op(id_q.ctrl.alu_op),
    .a(ex_a),
    .b(alu_b),
    .result(alu_result)
  );

  assign ex_d.ctrl       = id_q.ctrl;
  assign ex_d.pc         = id_q.pc;
  assign ex_d.alu_result = alu_result;
  assign ex_d.store_data = ex_b;
  assign ex_d.rd         = id_q.rd;
  assign ex_d.imm        = id_q.imm;

  stage_reg #(.payload_t(rv_pkg::ex_mem_t)) ex_mem_reg (
    .clk(clk), .sel(cut_ex_mem), .d(ex_d), .q(ex_q)
  );

  // ==========================================================================
  // memory
  // ==========================================================================

  // load data is not ready here, the bubble rules keep it from being needed
  always_comb begin
    case (ex_q.ctrl.wb_sel)
      rv_pkg::wb_imm: mem_fwd = ex_q.imm;
      rv_pkg::wb_pc4: mem_fwd = ex_q.pc + 32'd4;
      default:        mem_fwd = ex_q.alu_result;
    endcase
  end

  assign dm_en    = ex_q.ctrl.dm_en;
  assign dm_write = ex_q.ctrl.dm_write;
  assign dm_addr  = ex_q.alu_result;
  assign dm_wdata = ex_q.store_data;

  assign mem_d.rf_write   = ex_q.ctrl.rf_write;
  assign mem_d.wb_sel     = ex_q.ctrl.wb_sel;
  assign mem_d.rd         = ex_q.rd;
  assign mem_d.alu_result = ex_q.alu_result;
  assign mem_d.load_data  = dm_rdata;
  assign mem_d.imm        = ex_q.imm;
  assign mem_d.pc         = ex_q.pc;

  stage_reg #(.payload_t(rv_pkg::mem_wb_t)) mem_wb_reg (
    .clk(clk), .sel(cut_mem_wb), .d(mem_d), .q(mem_q)
  );

  // ==========================================================================
  // writeback and hazards
  // ==========================================================================

  always_comb begin
    case (mem_q.wb_sel)
      rv_pkg::wb_mem: wb_data = mem_q.load_data;
      rv_pkg::wb_imm: wb_data = mem_q.imm;
      rv_pkg::wb_pc4: wb_data = mem_q.pc + 32'd4;
      default:        wb_data = mem_q.alu_result;
    endcase
  end

  hazard_unit hazard_unit_inst (
    .id_rs1(id_rs1),
    .id_rs2(id_rs2),
    .ex_rs1(id_q.rs1),
    .ex_rs2(id_q.rs2),
    .ex_rd(id_q.rd),
    .mem_rd(ex_q.rd),
    .wb_rd(mem_q.rd),
    .id_branch(id_ctrl.branch),
    .ex_rf_write(id_q.ctrl.rf_write),
    .ex_is_load(id_q.ctrl.dm_en && !id_q.ctrl.dm_write),
    .mem_rf_write(ex_q.ctrl.rf_write),
    .mem_is_load(ex_q.ctrl.dm_en && !ex_q.ctrl.dm_write),
    .wb_rf_write(mem_q.rf_write),
    .rst(rst),
    .stall(stall),
    .redirect(redirect),
    .fwd_ex_a(fwd_ex_a),
    .fwd_ex_b(fwd_ex_b),
    .fwd_id_a(fwd_id_a),
    .fwd_id_b(fwd_id_b),
    .cut_if_id(cut_if_id),
    .cut_id_ex(cut_id_ex),
    .cut_ex_mem(cut_ex_mem),
    .cut_mem_wb(cut_mem_wb),
    .pc_hold(pc_hold)
  );

endmodule

`default_nettype wire

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam int n_programs   = 8;
  localparam int n_random     = 48;
  localparam int prog_len     = 56;
  localparam int reset_cycles = 10;
  localparam int drain_cycles = 8;
  localparam int max_cycles   = n_programs * (n_random * 6 + reset_cycles + drain_cycles + 4);

  // fetch address of the final jal
  localparam rv_pkg::word_t spin_pc = 32'(4 * (prog_len - 1));

  // instruction kinds of the generator and the model
  localparam logic [2:0] k_reg    = 3'd0;
  localparam logic [2:0] k_imm    = 3'd1;
  localparam logic [2:0] k_lui    = 3'd2;
  localparam logic [2:0] k_load   = 3'd3;
  localparam logic [2:0] k_store  = 3'd4;
  localparam logic [2:0] k_branch = 3'd5;
  localparam logic [2:0] k_jal    = 3'd6;

  logic              clk = 1'b0;
  logic              rst;
  logic              stall;
  rv_pkg::word_t     im_addr;
  rv_pkg::word_t     im_rdata;
  logic              dm_en;
  logic              dm_write;
  rv_pkg::word_t     dm_addr;
  rv_pkg::word_t     dm_wdata;
  rv_pkg::word_t     dm_rdata;

  integer            seed = 32'he738;
  int                prog_id = 0;
  int                got_count = 0;
  int                cycle_count = 0;

  rv_pkg::word_t     imem [0:63];
  rv_pkg::word_t     dmem [0:63];
  rv_pkg::word_t     model_mem [0:63];
  logic [2:0]        prog_kind [0:63];
  logic [2:0]        prog_f3 [0:63];
  logic              prog_alt [0:63];
  rv_pkg::reg_addr_t prog_rd [0:63];
  rv_pkg::reg_addr_t prog_rs1 [0:63];
  rv_pkg::reg_addr_t prog_rs2 [0:63];
  rv_pkg::word_t     prog_imm [0:63];
  rv_pkg::word_t     exp_addr [$];
  rv_pkg::word_t     exp_data [$];

  logic              last_rst = 1'b0;
  logic              last_stall = 1'b0;
  logic              last_en;
  logic              last_write;
  rv_pkg::word_t     last_addr;
  rv_pkg::word_t     last_wdata;
  rv_pkg::word_t     last_pc;

  always #4 clk = ~clk;

  rv_core rv_core_inst (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .im_addr(im_addr),
    .im_rdata(im_rdata),
    .dm_en(dm_en),
    .dm_write(dm_write),
    .dm_addr(dm_addr),
    .dm_wdata(dm_wdata),
    .dm_rdata(dm_rdata)
  );

  assign im_rdata = imem[im_addr[7:2]];
  assign dm_rdata = dmem[dm_addr[7:2]];

  task automatic compare_word(input rv_pkg::word_t got, input rv_pkg::word_t exp,
                              input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // odd multiplier gives every word of a program its own value
  function automatic rv_pkg::word_t fill_word(input int idx, input int p);
    return (32'(idx) * 32'h9e37_79b1) ^ (32'(p) << 24) ^ 32'h5a3c_0f96;
  endfunction

  // ==========================================================================
  // memory models and output checks
  // ==========================================================================

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 64; i++) begin
        dmem[i] <= fill_word(i, prog_id);
      end
    end else if (dm_en && dm_write && !stall) begin
      if (got_count >= exp_addr.size()) begin
        $display("unexpected store to address %h at %0t ns", dm_addr, $time);
        $display("RESULT: FAIL");
        $fatal(1, "unexpected store");
      end else begin
        compare_word(dm_addr, exp_addr[got_count], $sformatf("store %0d address", got_count));
        compare_word(dm_wdata, exp_data[got_count], $sformatf("store %0d data", got_count));
        dmem[dm_addr[7:2]] <= dm_wdata;
        got_count <= got_count + 1;
      end
    end
  end

  // a stall seen at the last edge froze the pc and the memory stage
  always @(posedge clk) begin
    if (last_rst) begin
      compare_word({31'b0, dm_en}, 32'd0, "dm_en after a reset edge");
      compare_word({31'b0, dm_write}, 32'd0, "dm_write after a reset edge");
      compare_word(im_addr, 32'd0, "im_addr after a reset edge");
    end else if (last_stall) begin
      compare_word({31'b0, dm_en}, {31'b0, last_en}, "dm_en across stall");
      compare_word({31'b0, dm_write}, {31'b0, last_write}, "dm_write across stall");
      compare_word(dm_addr, last_addr, "dm_addr across stall");
      compare_word(dm_wdata, last_wdata, "dm_wdata across stall");
      compare_word(im_addr, last_pc, "im_addr across stall");
    end
    last_rst   <= rst;
    last_stall <= stall;
    last_en    <= dm_en;
    last_write <= dm_write;
    last_addr  <= dm_addr;
    last_wdata <= dm_wdata;
    last_pc    <= im_addr;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the programs did not finish within %0d cycles", max_cycles);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ==========================================================================
  // program generator
  // ==========================================================================

  function automatic rv_pkg::word_t encode(input logic [2:0] kind, input logic [2:0] f3,
                                           input logic alt, input rv_pkg::reg_addr_t rd,
                                           input rv_pkg::reg_addr_t rs1,
                                           input rv_pkg::reg_addr_t rs2,
                                           input rv_pkg::word_t imm);
    case (kind)
      k_reg:    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_pkg::op_reg};
      k_imm:    return {imm[11:0], rs1, f3, rd, rv_pkg::op_imm};
      k_lui:    return {imm[31:12], rd, rv_pkg::op_lui};
      k_load:   return {imm[11:0], rs1, 3'b010, rd, rv_pkg::op_load};
      k_store:  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::op_store};
      k_branch: return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
      k_jal:    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal};
      default:  return '0;
    endcase
  endfunction

  task automatic set_instr(input int idx, input logic [2:0] kind, input logic [2:0] f3,
                           input logic alt, input rv_pkg::reg_addr_t rd,
                           input rv_pkg::reg_addr_t rs1, input rv_pkg::reg_addr_t rs2,
                           input rv_pkg::word_t imm);
    prog_kind[idx] = kind;
    prog_f3[idx]   = f3;
    prog_alt[idx]  = alt;
    prog_rd[idx]   = rd;
    prog_rs1[idx]  = rs1;
    prog_rs2[idx]  = rs2;
    prog_imm[idx]  = imm;
    imem[idx]      = encode(kind, f3, alt, rd, rs1, rs2, imm);
  endtask

  function automatic rv_pkg::word_t word_offset();
    return {24'b0, 6'(rnd(64)), 2'b00};
  endfunction

  // forward by 2 to 4 instructions
  function automatic rv_pkg::word_t jump_offset();
    return 32'(4 * (2 + rnd(3)));
  endfunction

  function automatic logic [2:0] branch_f3(input int n);
    case (n)
      0:       return 3'b000;
      1:       return 3'b001;
      2:       return 3'b100;
      3:       return 3'b101;
      4:       return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  task automatic build_program();
    int                sel;
    logic [2:0]        kind;
    logic [2:0]        f3;
    logic              alt;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    logic [11:0]       imm12;
    rv_pkg::word_t     imm;
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;
    end
    // first store writes x0
    set_instr(0, k_store, 3'b010, 1'b0, 5'd0, 5'd0, 5'd0, word_offset());
    for (int i = 1; i < n_random; i++) begin
      sel   = rnd(16);
      f3    = 3'(rnd(8));
      alt   = 1'b0;
      rd    = 5'(rnd(8));
      rs1   = 5'(rnd(8));
      rs2   = 5'(rnd(8));
      imm12 = 12'(rnd(4096));
      imm   = {{20{imm12[11]}}, imm12};
      if (sel < 5) begin
        kind = k_reg;
        if (f3 == 3'b000 || f3 == 3'b101) begin
          alt = 1'(rnd(2));
        end
      end else if (sel < 9) begin
        kind = k_imm;
        rs2  = '0;
        if (f3 == 3'b001) begin
          imm = {27'b0, imm12[4:0]};
        end else if (f3 == 3'b101) begin
          alt = 1'(rnd(2));
          imm = {21'b0, alt, 5'b0, imm12[4:0]};
        end
      end else if (sel == 9) begin
        kind = k_lui;
        rs1  = '0;
        rs2  = '0;
        imm  = {20'(rnd(1 << 20)), 12'b0};
      end else if (sel < 12) begin
        kind = k_load;
        f3   = 3'b010;
        rs1  = '0;
        rs2  = '0;
        imm  = word_offset();
      end else if (sel < 14) begin
        kind = k_store;
        f3   = 3'b010;
        rd   = '0;
        rs1  = '0;
        imm  = word_offset();
      end else if (sel == 14) begin
        kind = k_branch;
        rd   = '0;
        f3   = branch_f3(rnd(6));
        imm  = jump_offset();
      end else begin
        kind = k_jal;
        f3   = '0;
        rs1  = '0;
        rs2  = '0;
        imm  = jump_offset();
      end
      set_instr(i, kind, f3, alt, rd, rs1, rs2, imm);
    end
    // dump x1 to x7, then spin on a jal to itself
    for (int r = 1; r < 8; r++) begin
      set_instr(n_random + r - 1, k_store, 3'b010, 1'b0, 5'd0, 5'd0, 5'(r),
                32'(224 + 4 * (r - 1)));
    end
    set_instr(prog_len - 1, k_jal, 3'b000, 1'b0, 5'd0, 5'd0, 5'd0, 32'd0);
  endtask

  // ==========================================================================
  // instruction-set model
  // ==========================================================================

  function automatic rv_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::word_t a,
                                              input rv_pkg::word_t b);
    rv_pkg::word_t r;
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = {31'b0, $signed(a) < $signed(b)};
      3'b011: r = {31'b0, a < b};
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input rv_pkg::word_t a,
                                        input rv_pkg::word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic run_model(input int p);
    rv_pkg::word_t regs [0:31];
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t res;
    rv_pkg::word_t addr;
    int            idx;
    int            next_idx;
    int            steps;
    logic          done;
    logic          writes;
    for (int i = 0; i < 64; i++) begin
      model_mem[i] = fill_word(i, p);
    end
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    idx   = 0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 4 * prog_len) begin
      a        = regs[prog_rs1[idx]];
      b        = regs[prog_rs2[idx]];
      res      = '0;
      writes   = 1'b1;
      next_idx = idx + 1;
      case (prog_kind[idx])
        k_reg:  res = alu_model(prog_f3[idx], prog_alt[idx], a, b);
        k_imm:  res = alu_model(prog_f3[idx], prog_alt[idx], a, prog_imm[idx]);
        k_lui:  res = prog_imm[idx];
        k_load: begin
          addr = a + prog_imm[idx];
          res  = model_mem[addr[7:2]];
        end
        k_store: begin
          addr   = a + prog_imm[idx];
          writes = 1'b0;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
          model_mem[addr[7:2]] = b;
        end
        k_branch: begin
          writes = 1'b0;
          if (branch_taken(prog_f3[idx], a, b)) begin
            next_idx = idx + int'(prog_imm[idx] >> 2);
          end
        end
        default: begin
          res      = 32'(idx * 4 + 4);
          next_idx = idx + int'(prog_imm[idx] >> 2);
          done     = prog_imm[idx] == '0;
        end
      endcase
      if (writes && prog_rd[idx] != '0) begin
        regs[prog_rd[idx]] = res;
      end
      idx = next_idx;
      steps++;
    end
    if (!done) begin
      $display("the model did not reach the final jal of program %0d", p);
      $display("RESULT: FAIL");
      $fatal(1, "model runaway");
    end
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================

  task automatic run_program(input int p, input logic use_stall);
    @(posedge clk);
    rst     <= 1'b1;
    stall   <= 1'b0;
    prog_id = p;
    @(posedge clk);
    build_program();
    run_model(p);
    repeat (reset_cycles - 1) @(posedge clk);
    rst <= 1'b0;
    // run until the final jal is fetched, roughly one stalled cycle in four
    while (im_addr !== spin_pc) begin
      @(posedge clk);
      if (use_stall) begin
        stall <= (rnd(4) == 0);
      end else begin
        stall <= 1'b0;
      end
    end
    @(posedge clk);
    stall <= 1'b0;
    repeat (drain_cycles) @(posedge clk);
    compare_word(got_count, exp_addr.size(), $sformatf("store count after program %0d", p));
  endtask

  initial begin
    rst   = 1'b1;
    stall = 1'b0;
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;
    end
    for (int p = 0; p < n_programs; p++) begin
      run_program(p, p % 2 == 1);
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
common/rv_pkg.sv
core/stage_reg.sv
core/decode_unit.sv
core/reg_file.sv
core/alu.sv
core/hazard_unit.sv
core/rv_core.sv
bench/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f files.f -o tb_rv_core_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/tb_rv_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^RESULT: PASS$"; then
  exit 0
fi
echo "pass message not found"
exit 1
